// ==== core_decode.f ====
+incdir+hdl
hdl/core_uarch_pkg.sv
hdl/decode_bus_if.sv
hdl/core_decode_data.sv
hdl/core_decode_ldst.sv
hdl/core_decode_mux.sv
hdl/core_reglist_counter.sv
hdl/core_ldm_sequencer.sv
hdl/core_decode.sv
test/core_decode_tb.sv

// ==== hdl/core_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_decode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  core_uarch_pkg::word       insn,
	input  logic                      insn_valid,
	output logic                      stall,
	output logic                      uop_valid,
	output core_uarch_pkg::insn_group uop_group,
	output logic[3:0]                 uop_cond,
	output core_uarch_pkg::alu_op     uop_alu_op,
	output core_uarch_pkg::reg_num    uop_rd,
	output core_uarch_pkg::reg_num    uop_rn,
	output logic                      uop_uses_rn,
	output logic                      uop_update_flags,
	output logic                      uop_writeback,
	output logic                      snd_is_imm,
	output core_uarch_pkg::word       snd_imm,
	output core_uarch_pkg::reg_num    snd_rm,
	output core_uarch_pkg::shift_type snd_shift,
	output logic[4:0]                 snd_shift_imm,
	output logic                      ldst_load,
	output logic                      ldst_byte,
	output logic                      ldst_up,
	output logic[11:0]                ldst_offset,
	output logic                      base_writeback,
	output logic                      undefined
);

	core_uarch_pkg::data_decode uop_data;
	core_uarch_pkg::snd_decode  uop_snd;
	core_uarch_pkg::ldst_decode uop_ldst;

	decode_bus_if bus ();

	core_decode_mux u_mux (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn       (insn),
		.insn_valid (insn_valid),
		.stall      (stall),
		.bus        (bus.src)
	);

	core_ldm_sequencer u_seq (
		.clk            (clk),
		.rst_n          (rst_n),
		.bus            (bus.dst),
		.stall          (stall),
		.uop_valid      (uop_valid),
		.uop_group      (uop_group),
		.uop_cond       (uop_cond),
		.uop_data       (uop_data),
		.uop_snd        (uop_snd),
		.uop_ldst       (uop_ldst),
		.uop_offset     (ldst_offset),
		.base_writeback (base_writeback),
		.undefined      (undefined)
	);

	// flatten for the pins
	assign uop_alu_op       = uop_data.op;
	assign uop_rd           = uop_data.rd;
	assign uop_rn           = uop_data.rn;
	assign uop_uses_rn      = uop_data.uses_rn;
	assign uop_update_flags = uop_data.update_flags;
	assign uop_writeback    = uop_data.writeback;

	assign snd_is_imm    = uop_snd.is_imm;
	assign snd_imm       = uop_snd.imm;
	assign snd_rm        = uop_snd.r;
	assign snd_shift     = uop_snd.shift;
	assign snd_shift_imm = uop_snd.shift_imm;

	assign ldst_load = uop_ldst.load;
	assign ldst_byte = uop_ldst.is_byte;
	assign ldst_up   = uop_ldst.up;

endmodule

`default_nettype wire

// ==== hdl/core_decode_data.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_decode_data (
	input  core_uarch_pkg::word        insn,
	output core_uarch_pkg::data_decode data,
	output core_uarch_pkg::snd_decode  snd,
	output logic                       snd_undefined,
	output core_uarch_pkg::data_decode mul_data,
	output core_uarch_pkg::snd_decode  mul_snd
);

	core_uarch_pkg::alu_op op;
	logic                  is_cmp;
	logic[31:0]            imm_zx;
	logic[63:0]            imm_dbl;

	assign op      = core_uarch_pkg::alu_op'(insn[24:21]);
	assign is_cmp  = insn[24:23] == 2'b10; // tst teq cmp cmn
	assign imm_zx  = {24'd0, insn[7:0]};
	assign imm_dbl = {imm_zx, imm_zx} >> {insn[11:8], 1'b0}; // low half is the ror

	// ####################
	always_comb begin
		data.op           = op;
		data.rd           = insn[15:12];
		data.rn           = insn[19:16];
		data.uses_rn      = !(op inside {core_uarch_pkg::alu_mov, core_uarch_pkg::alu_mvn});
		data.update_flags = insn[20] | is_cmp;
		data.writeback    = !is_cmp; // compares only set flags

		snd.is_imm = insn[25];
		snd.r      = insn[3:0];
		if (insn[25]) begin
			snd.imm       = imm_dbl[31:0];
			snd.shift     = core_uarch_pkg::shift_lsl;
			snd.shift_imm = 5'd0;
		end else begin
			snd.imm       = 32'd0;
			snd.shift     = core_uarch_pkg::shift_type'(insn[6:5]);
			snd.shift_imm = insn[11:7];
		end
	end

	// shift by register, also catches the misc 1xx1 space
	assign snd_undefined = !insn[25] && insn[4];

	// ####################
	// mul: rd 19:16, rs 11:8, rm 3:0
	always_comb begin
		mul_data.op           = core_uarch_pkg::alu_mov; // not looked at for mul
		mul_data.rd           = insn[19:16];
		mul_data.rn           = insn[11:8];
		mul_data.uses_rn      = 1'b1;
		mul_data.update_flags = insn[20];
		mul_data.writeback    = 1'b1;

		mul_snd        = '0;
		mul_snd.is_imm = 1'b0;
		mul_snd.r      = insn[3:0];
	end

endmodule

`default_nettype wire

// ==== hdl/core_decode_ldst.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_decode_ldst (
	input  core_uarch_pkg::word        insn,
	output core_uarch_pkg::ldst_decode single,
	output core_uarch_pkg::ldst_decode multiple,
	output core_uarch_pkg::snd_decode  single_snd,
	output logic                       list_empty
);

	// ldr/str
	always_comb begin
		single.load      = insn[20];
		single.writeback = insn[21];
		single.is_byte   = insn[22];
		single.up        = insn[23];
		single.pre_index = insn[24];
		single.imm       = insn[11:0];
		single.reglist   = 16'd0;
		single.user_mode = !insn[24] && insn[21]; // ldrt/strt form

		single_snd.is_imm = !insn[25]; // I set means register offset here
		single_snd.r      = insn[3:0];
		if (insn[25]) begin
			single_snd.imm       = 32'd0;
			single_snd.shift     = core_uarch_pkg::shift_type'(insn[6:5]);
			single_snd.shift_imm = insn[11:7];
		end else begin
			single_snd.imm       = {20'd0, insn[11:0]};
			single_snd.shift     = core_uarch_pkg::shift_lsl;
			single_snd.shift_imm = 5'd0;
		end
	end

	// ldm/stm
	always_comb begin
		multiple.load      = insn[20];
		multiple.writeback = insn[21];
		multiple.user_mode = insn[22]; // S bit
		multiple.up        = insn[23];
		multiple.pre_index = insn[24];
		multiple.is_byte   = 1'b0;
		multiple.imm       = 12'd0;
		multiple.reglist   = insn[15:0];
	end

	assign list_empty = insn[15:0] == 16'd0;

endmodule

`default_nettype wire

// ==== hdl/core_decode_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "core_isa_params.svh"

module core_decode_mux (
	input  logic                clk,
	input  logic                rst_n,
	input  core_uarch_pkg::word insn,
	input  logic                insn_valid,
	input  logic                stall,
	decode_bus_if.src           bus
);

	core_uarch_pkg::data_decode dp_data;
	core_uarch_pkg::data_decode mul_data;
	core_uarch_pkg::snd_decode  dp_snd;
	core_uarch_pkg::snd_decode  mul_snd;
	core_uarch_pkg::snd_decode  ldst_snd;
	core_uarch_pkg::ldst_decode ldst_single;
	core_uarch_pkg::ldst_decode ldst_multiple;
	logic                       dp_snd_undefined;
	logic                       list_empty;
	logic                       psr_form;

	core_decode_data u_data (
		.insn          (insn),
		.data          (dp_data),
		.snd           (dp_snd),
		.snd_undefined (dp_snd_undefined),
		.mul_data      (mul_data),
		.mul_snd       (mul_snd)
	);

	core_decode_ldst u_ldst (
		.insn       (insn),
		.single     (ldst_single),
		.multiple   (ldst_multiple),
		.single_snd (ldst_snd),
		.list_empty (list_empty)
	);

	assign bus.valid = insn_valid & ~stall;
	assign bus.cond  = `FIELD_COND(insn);
	assign psr_form  = insn[24:23] == 2'b10 && !insn[20]; // compare without S is mrs/msr/bx

	always_comb begin
		bus.group     = core_uarch_pkg::grp_none;
		bus.is_mult   = 1'b0;
		bus.undefined = 1'b0;

		bus.data         = '0;
		bus.data.uses_rn = 1'b1;
		bus.snd          = '0;
		bus.snd.is_imm   = 1'b1;
		bus.ldst         = '0;

		// mul has to win over alu
		priority casez (`FIELD_OP(insn))
			`GROUP_B: begin
				bus.group        = core_uarch_pkg::grp_branch;
				bus.data.uses_rn = insn[24];
				if (insn[24]) begin // bl: lr = pc - 4
					bus.data.op        = core_uarch_pkg::alu_sub;
					bus.data.rd        = `R14;
					bus.data.rn        = `R15;
					bus.data.writeback = 1'b1;
					bus.snd.imm        = 32'd4;
				end
			end

			`GROUP_MUL: begin
				bus.group = core_uarch_pkg::grp_mul;
				bus.data  = mul_data;
				bus.snd   = mul_snd;
			end

			`GROUP_ALU: begin
				bus.group     = core_uarch_pkg::grp_alu;
				bus.data      = dp_data;
				bus.snd       = dp_snd;
				bus.undefined = dp_snd_undefined | psr_form;
			end

			`GROUP_LDST_SINGLE: begin
				bus.group          = core_uarch_pkg::grp_ldst;
				bus.ldst           = ldst_single;
				bus.snd            = ldst_snd;
				bus.data.op        = insn[23] ? core_uarch_pkg::alu_add : core_uarch_pkg::alu_sub;
				bus.data.rd        = insn[15:12];
				bus.data.rn        = insn[19:16];
				bus.data.writeback = ldst_single.load | ldst_single.writeback;
				bus.undefined      = insn[25] & insn[4]; // media space
			end

			`GROUP_LDST_MULT: begin
				bus.group          = core_uarch_pkg::grp_ldst;
				bus.is_mult        = 1'b1;
				bus.ldst           = ldst_multiple;
				bus.snd.imm        = 32'd4;
				bus.data.op        = insn[23] ? core_uarch_pkg::alu_add : core_uarch_pkg::alu_sub;
				bus.data.rn        = insn[19:16]; // rd filled in per uop
				bus.data.writeback = ldst_multiple.load;
				bus.undefined      = list_empty;
			end

			`INSN_SWI: begin
				bus.group        = core_uarch_pkg::grp_swi;
				bus.data.uses_rn = 1'b0;
			end

			default:
				bus.undefined = 1'b1;
		endcase

		if (bus.undefined) begin
			bus.group   = core_uarch_pkg::grp_undef;
			bus.is_mult = 1'b0;
			bus.data    = '0;
			bus.snd     = '0;
			bus.ldst    = '0;
		end
	end

	// nothing accepted by the sequencer may leave the mux unclassified
	assert property (@(posedge clk) disable iff (!rst_n)
		bus.valid |-> bus.group != core_uarch_pkg::grp_none);

endmodule

`default_nettype wire

// ==== hdl/core_isa_params.svh ====
`ifndef CORE_ISA_PARAMS_SVH
`define CORE_ISA_PARAMS_SVH

// opcode key for group matching, bits 27..20 then 7..4
`define FIELD_OP(w)   {w[27:20], w[7:4]}
`define FIELD_COND(w) w[31:28]

// ####################
// group patterns over FIELD_OP, matched by priority
`define GROUP_B            12'b101?_????_????
`define GROUP_MUL          12'b0000_000?_1001
`define GROUP_ALU          12'b00??_????_????
`define GROUP_LDST_SINGLE  12'b01??_????_????
`define GROUP_LDST_MULT    12'b100?_????_????
`define INSN_SWI           12'b1111_????_????

// ####################
// data processing opcodes, bits 24..21
`define ALU_AND 4'b0000
`define ALU_EOR 4'b0001
`define ALU_SUB 4'b0010
`define ALU_RSB 4'b0011
`define ALU_ADD 4'b0100
`define ALU_ADC 4'b0101
`define ALU_SBC 4'b0110
`define ALU_RSC 4'b0111
`define ALU_TST 4'b1000
`define ALU_TEQ 4'b1001
`define ALU_CMP 4'b1010
`define ALU_CMN 4'b1011
`define ALU_ORR 4'b1100
`define ALU_MOV 4'b1101
`define ALU_BIC 4'b1110
`define ALU_MVN 4'b1111

`define R14 4'd14 // lr
`define R15 4'd15 // pc

`endif

// ==== hdl/core_ldm_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_ldm_sequencer (
	input  logic                       clk,
	input  logic                       rst_n,
	decode_bus_if.dst                  bus,
	output logic                       stall,
	output logic                       uop_valid,
	output core_uarch_pkg::insn_group  uop_group,
	output logic[3:0]                  uop_cond,
	output core_uarch_pkg::data_decode uop_data,
	output core_uarch_pkg::snd_decode  uop_snd,
	output core_uarch_pkg::ldst_decode uop_ldst,
	output logic[11:0]                 uop_offset,
	output logic                       base_writeback,
	output logic                       undefined
);

	core_uarch_pkg::seq_state   state;
	core_uarch_pkg::data_decode r_data;
	core_uarch_pkg::reg_num     cur_reg;
	logic[4:0]                  count;
	logic[3:0]                  index;
	logic[4:0]                  mult;
	logic                       last;
	logic                       load;
	logic                       step;

	core_reglist_counter u_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.step    (step),
		.reglist (bus.ldst.reglist),
		.count   (count),
		.index   (index),
		.cur_reg (cur_reg),
		.last    (last)
	);

	assign load  = bus.valid & bus.is_mult;
	assign step  = (state == core_uarch_pkg::st_expand) & ~last;
	assign stall = step; // source holds until the last uop is out

	// ####################
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= core_uarch_pkg::st_idle;
			uop_valid <= 1'b0;
			undefined <= 1'b0;
		end else begin
			uop_valid <= bus.valid | step;
			undefined <= bus.valid & bus.undefined;
			if (bus.valid)
				state <= bus.is_mult ? core_uarch_pkg::st_expand : core_uarch_pkg::st_idle;
			else if (!step)
				state <= core_uarch_pkg::st_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.valid) begin
			uop_group <= bus.group;
			uop_cond  <= bus.cond;
			r_data    <= bus.data;
			uop_snd   <= bus.snd;
			uop_ldst  <= bus.ldst;
		end
	end

	// word multiplier by addressing mode
	always_comb begin
		unique case ({uop_ldst.pre_index, uop_ldst.up})
			2'b01: mult = {1'b0, index};               // ia
			2'b11: mult = {1'b0, index} + 5'd1;        // ib
			2'b00: mult = count - {1'b0, index} - 5'd1; // da
			2'b10: mult = count - {1'b0, index};       // db
		endcase
	end

	always_comb begin
		uop_data       = r_data;
		uop_offset     = uop_ldst.imm;
		base_writeback = uop_ldst.writeback;
		if (state == core_uarch_pkg::st_expand) begin
			uop_data.rd    = cur_reg;
			uop_offset     = {5'd0, mult, 2'b00};
			base_writeback = uop_ldst.writeback & last;
		end
	end

	// a fresh uop out of idle must come from an accepted word
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == core_uarch_pkg::st_idle && $rose(uop_valid)) |-> $past(bus.valid));

endmodule

`default_nettype wire

// ==== hdl/core_reglist_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_reglist_counter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  logic                   step,
	input  logic[15:0]             reglist,
	output logic[4:0]              count,
	output logic[3:0]              index,
	output core_uarch_pkg::reg_num cur_reg,
	output logic                   last
);

	logic[15:0] mask; // registers not yet emitted
	logic[4:0]  pop;

	always_comb begin
		pop = 5'd0;
		for (int i = 0; i < 16; i++)
			pop = pop + {4'd0, reglist[i]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mask  <= 16'd0;
			count <= 5'd0;
			index <= 4'd0;
		end else if (load) begin
			mask  <= reglist;
			count <= pop;
			index <= 4'd0;
		end else if (step) begin
			mask  <= mask & (mask - 16'd1); // drop lowest bit
			index <= index + 4'd1;
		end
	end

	// lowest set bit wins
	always_comb begin
		cur_reg = 4'd0;
		for (int i = 15; i >= 0; i--)
			if (mask[i])
				cur_reg = core_uarch_pkg::reg_num'(i);
	end

	assign last = (mask & (mask - 16'd1)) == 16'd0;

	assert property (@(posedge clk) disable iff (!rst_n) step |-> mask != 16'd0);

endmodule

`default_nettype wire

// ==== hdl/core_uarch_pkg.sv ====
`default_nettype none

`include "core_isa_params.svh"

package core_uarch_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	typedef enum logic [3:0] {
		alu_and = `ALU_AND,
		alu_eor = `ALU_EOR,
		alu_sub = `ALU_SUB,
		alu_rsb = `ALU_RSB,
		alu_add = `ALU_ADD,
		alu_adc = `ALU_ADC,
		alu_sbc = `ALU_SBC,
		alu_rsc = `ALU_RSC,
		alu_tst = `ALU_TST,
		alu_teq = `ALU_TEQ,
		alu_cmp = `ALU_CMP,
		alu_cmn = `ALU_CMN,
		alu_orr = `ALU_ORR,
		alu_mov = `ALU_MOV,
		alu_bic = `ALU_BIC,
		alu_mvn = `ALU_MVN
	} alu_op;

	typedef enum logic [2:0] {
		grp_none,
		grp_alu,
		grp_mul,
		grp_branch,
		grp_ldst,
		grp_swi,
		grp_undef
	} insn_group;

	typedef enum logic [1:0] {shift_lsl, shift_lsr, shift_asr, shift_ror} shift_type;

	// second operand, imm already expanded
	typedef struct packed {
		logic      is_imm;
		word       imm;
		reg_num    r;
		shift_type shift;
		logic[4:0] shift_imm;
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rd;
		reg_num rn;
		logic   uses_rn;
		logic   update_flags;
		logic   writeback;
	} data_decode;

	typedef struct packed {
		logic       load;
		logic       is_byte;
		logic       up;
		logic       pre_index;
		logic       writeback;  // base register update
		logic[11:0] imm;
		logic[15:0] reglist;
		logic       user_mode;
	} ldst_decode;

	typedef enum logic {st_idle, st_expand} seq_state;

endpackage

`default_nettype wire

// ==== hdl/decode_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one decoded instruction, group mux to sequencer
interface decode_bus_if;

	logic                       valid;
	core_uarch_pkg::insn_group  group;
	logic[3:0]                  cond;
	core_uarch_pkg::data_decode data;
	core_uarch_pkg::snd_decode  snd;
	core_uarch_pkg::ldst_decode ldst;
	logic                       is_mult;  // ldm/stm, needs expansion
	logic                       undefined;

	modport src (
		output valid, group, cond, data, snd, ldst, is_mult, undefined
	);

	modport dst (
		input valid, group, cond, data, snd, ldst, is_mult, undefined
	);

endinterface

`default_nettype wire

// ==== test/core_decode_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "core_isa_params.svh"

module core_decode_tb;

	localparam int n_alu_imm = 24;
	localparam int n_alu_reg = 16;
	localparam int n_ldst    = 16;
	localparam int n_block   = 12;
	// each block also issues a held follower, 14 fixed words for branch mul swi undef
	localparam int insn_total  = n_alu_imm + n_alu_reg + n_ldst + 2 * n_block + 14;
	localparam int cycle_limit = 16 + 40 * insn_total;

	// bit 32 set means the field is not checked
	typedef struct packed {
		logic[32:0] group, cond, op, rd, rn;
		logic[32:0] uses_rn, update_flags, writeback;
		logic[32:0] is_imm, imm, rm, shift, shift_imm;
		logic[32:0] load, is_byte, up, offset, base_wb, undef;
	} exp_t;

	logic                      clk;
	logic                      rst_n;
	logic[31:0]                insn;
	logic                      insn_valid;
	logic                      stall;
	logic                      uop_valid;
	core_uarch_pkg::insn_group uop_group;
	logic[3:0]                 uop_cond;
	core_uarch_pkg::alu_op     uop_alu_op;
	core_uarch_pkg::reg_num    uop_rd;
	core_uarch_pkg::reg_num    uop_rn;
	logic                      uop_uses_rn;
	logic                      uop_update_flags;
	logic                      uop_writeback;
	logic                      snd_is_imm;
	logic[31:0]                snd_imm;
	core_uarch_pkg::reg_num    snd_rm;
	core_uarch_pkg::shift_type snd_shift;
	logic[4:0]                 snd_shift_imm;
	logic                      ldst_load;
	logic                      ldst_byte;
	logic                      ldst_up;
	logic[11:0]                ldst_offset;
	logic                      base_writeback;
	logic                      undefined;

	logic[31:0] lfsr;
	int         errors = 0;
	int         checks = 0;
	int         cycles;

	core_decode dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ####################
	function automatic logic[31:0] take_bits(input int n);
		logic[31:0] v;
		int         i;
		v = 32'd0;
		for (i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha300_0000 : lfsr >> 1; // taps 32 30 26 25
		end
		return v;
	endfunction

	function automatic int list_size(input logic[15:0] list);
		int i;
		int n;
		n = 0;
		for (i = 0; i < 16; i++)
			n += list[i];
		return n;
	endfunction

	// expected micro-op k of instruction w
	function automatic exp_t ref_uop(input logic[31:0] w, input int k);
		exp_t       e;
		logic[31:0] rot;
		int         i;
		int         n;
		int         seen;
		int         mult;
		e         = '1;
		e.cond    = w[31:28];
		e.undef   = 0;
		e.base_wb = 0;
		if (w[27:25] == 3'b101) begin
			e.group = core_uarch_pkg::grp_branch;
			if (w[24]) begin // link is lr = pc - 4
				e.op        = `ALU_SUB;
				e.rd        = `R14;
				e.rn        = `R15;
				e.writeback = 1;
				e.is_imm    = 1;
				e.imm       = 4;
			end
		end else if (w[27:21] == 7'd0 && w[7:4] == 4'b1001) begin
			e.group        = core_uarch_pkg::grp_mul;
			e.rd           = w[19:16];
			e.rn           = w[11:8];
			e.rm           = w[3:0];
			e.is_imm       = 0;
			e.update_flags = w[20];
		end else if (w[27:26] == 2'b00 && !(!w[25] && w[4]) && !(w[24:23] == 2'b10 && !w[20])) begin
			e.group        = core_uarch_pkg::grp_alu;
			e.op           = w[24:21];
			e.rd           = w[15:12];
			e.rn           = w[19:16];
			e.uses_rn      = w[24:21] != `ALU_MOV && w[24:21] != `ALU_MVN;
			e.update_flags = w[20] || w[24:23] == 2'b10;
			e.writeback    = w[24:23] != 2'b10; // tst teq cmp cmn
			e.is_imm       = w[25];
			if (w[25]) begin
				rot = {24'd0, w[7:0]};
				for (i = 0; i < 2 * w[11:8]; i++)
					rot = {rot[0], rot[31:1]};
				e.imm = rot;
			end else begin
				e.rm        = w[3:0];
				e.shift     = w[6:5];
				e.shift_imm = w[11:7];
			end
		end else if (w[27:26] == 2'b01 && !(w[25] && w[4])) begin
			e.group     = core_uarch_pkg::grp_ldst;
			e.rd        = w[15:12];
			e.rn        = w[19:16];
			e.writeback = w[20] || w[21];
			e.load      = w[20];
			e.is_byte   = w[22];
			e.up        = w[23];
			e.base_wb   = '1;
			e.is_imm    = !w[25];
			if (!w[25]) begin
				e.imm    = w[11:0];
				e.offset = w[11:0];
			end else begin
				e.rm        = w[3:0];
				e.shift     = w[6:5];
				e.shift_imm = w[11:7];
			end
		end else if (w[27:25] == 3'b100 && w[15:0] != 16'd0) begin
			n    = list_size(w[15:0]);
			seen = 0;
			for (i = 0; i < 16; i++)
				if (w[i]) begin
					if (seen == k)
						e.rd = i;
					seen++;
				end
			case (w[24:23])
				2'b01:   mult = k;         // ia
				2'b11:   mult = k + 1;     // ib
				2'b00:   mult = n - 1 - k; // da
				default: mult = n - k;     // db
			endcase
			e.group   = core_uarch_pkg::grp_ldst;
			e.rn      = w[19:16];
			e.load    = w[20];
			e.up      = w[23];
			e.is_byte = 0;
			e.offset  = 4 * mult;
			e.base_wb = w[21] && k == n - 1;
		end else if (w[27:24] == 4'hf) begin
			e.group = core_uarch_pkg::grp_swi;
		end else begin
			e.group = core_uarch_pkg::grp_undef;
			e.undef = 1;
		end
		return e;
	endfunction

	function automatic logic[31:0] make_alu_imm();
		logic[31:0] w;
		w        = take_bits(32);
		w[27:25] = 3'b001;
		if (w[24:23] == 2'b10)
			w[20] = 1'b1; // compare without S is a psr transfer
		return w;
	endfunction

	// ####################
	task automatic check(input string name, input string field, input logic[32:0] exp,
			input logic[31:0] act);
		if (!exp[32]) begin
			checks++;
			assert (act === exp[31:0]) else begin
				errors++;
				$display("FAIL %s %s: expected %0h, actual %0h", name, field, exp[31:0], act);
			end
		end
	endtask

	task automatic check_uop(input string name, input exp_t e);
		check(name, "group", e.group, uop_group);
		check(name, "cond", e.cond, uop_cond);
		check(name, "alu_op", e.op, uop_alu_op);
		check(name, "rd", e.rd, uop_rd);
		check(name, "rn", e.rn, uop_rn);
		check(name, "uses_rn", e.uses_rn, uop_uses_rn);
		check(name, "update_flags", e.update_flags, uop_update_flags);
		check(name, "writeback", e.writeback, uop_writeback);
		check(name, "snd_is_imm", e.is_imm, snd_is_imm);
		check(name, "snd_imm", e.imm, snd_imm);
		check(name, "snd_rm", e.rm, snd_rm);
		check(name, "snd_shift", e.shift, snd_shift);
		check(name, "snd_shift_imm", e.shift_imm, snd_shift_imm);
		check(name, "ldst_load", e.load, ldst_load);
		check(name, "ldst_byte", e.is_byte, ldst_byte);
		check(name, "ldst_up", e.up, ldst_up);
		check(name, "ldst_offset", e.offset, ldst_offset);
		check(name, "base_writeback", e.base_wb, base_writeback);
		check(name, "undefined", e.undef, undefined);
	endtask

	task automatic send_insn(input logic[31:0] w);
		@(negedge clk);
		insn       = w;
		insn_valid = 1'b1;
		while (stall)
			@(negedge clk);
	endtask

	// cycles from acceptance until uop_valid
	task automatic await_uop(input string name, output int lat);
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!uop_valid && lat < 8);
		assert (uop_valid) else begin
			errors++;
			$display("%s: no micro-op came out within %0d cycles", name, lat);
		end
	endtask

	task automatic issue_single(input string name, input logic[31:0] w);
		int lat;
		send_insn(w);
		await_uop(name, lat);
		insn_valid = 1'b0;
		check(name, "latency", 1, lat);
		check_uop(name, ref_uop(w, 0));
		@(negedge clk);
		check(name, "uop_valid after pulse", 0, uop_valid);
	endtask

	task automatic issue_block(input string name, input logic[31:0] w, input logic[31:0] next_w);
		int lat;
		int n;
		int k;
		n = list_size(w[15:0]);
		send_insn(w);
		await_uop(name, lat);
		insn = next_w; // held while the block expands
		check(name, "latency", 1, lat);
		for (k = 0; k < n; k++) begin
			if (k > 0)
				@(negedge clk);
			check(name, "uop_valid", 1, uop_valid);
			check(name, "stall", k < n - 1, stall);
			check_uop(name, ref_uop(w, k));
		end
		@(negedge clk);
		insn_valid = 1'b0;
		check(name, "held uop_valid", 1, uop_valid);
		check_uop({name, " held"}, ref_uop(next_w, 0));
		@(negedge clk);
		check(name, "uop_valid after held", 0, uop_valid);
	endtask

	// ####################
	task automatic reset_state();
		@(negedge clk);
		check("reset", "uop_valid", 0, uop_valid);
		check("reset", "stall", 0, stall);
		check("reset", "undefined", 0, undefined);
	endtask

	task automatic data_imm_ops();
		int i;
		for (i = 0; i < n_alu_imm; i++)
			issue_single("alu_imm", make_alu_imm());
	endtask

	task automatic data_reg_ops();
		int         i;
		logic[31:0] w;
		for (i = 0; i < n_alu_reg; i++) begin
			w        = take_bits(32);
			w[27:25] = 3'b000;
			w[4]     = 1'b0; // shift by immediate
			if (w[24:23] == 2'b10)
				w[20] = 1'b1;
			issue_single("alu_reg", w);
		end
	endtask

	task automatic branches();
		int         i;
		logic[31:0] w;
		for (i = 0; i < 4; i++) begin
			w        = take_bits(32);
			w[27:25] = 3'b101;
			w[24]    = i[0]; // odd ones link
			issue_single("branch", w);
		end
	endtask

	task automatic multiplies();
		int         i;
		logic[31:0] w;
		for (i = 0; i < 4; i++) begin
			w        = take_bits(32);
			w[27:21] = 7'd0;
			w[15:12] = 4'd0;
			w[7:4]   = 4'b1001;
			issue_single("mul", w);
		end
	endtask

	task automatic swi_calls();
		int         i;
		logic[31:0] w;
		for (i = 0; i < 2; i++) begin
			w        = take_bits(32);
			w[27:24] = 4'hf;
			issue_single("swi", w);
		end
	endtask

	task automatic single_transfers();
		int         i;
		logic[31:0] w;
		for (i = 0; i < n_ldst; i++) begin
			w        = take_bits(32);
			w[27:26] = 2'b01;
			w[4]     = 1'b0;
			issue_single("ldr_str", w);
		end
	endtask

	task automatic block_transfers();
		int         i;
		logic[31:0] w;
		for (i = 0; i < n_block; i++) begin
			w        = take_bits(32);
			w[27:25] = 3'b100;
			w[24:23] = i[1:0]; // da ia db ib in turn
			w[22]    = 1'b0;
			if (w[15:0] == 16'd0)
				w[0] = 1'b1;
			issue_block("ldm_stm", w, make_alu_imm());
		end
	endtask

	task automatic undefined_encodings();
		issue_single("undef_reg_shift", 32'he081_0312); // add r0, r1, r2, lsl r3
		issue_single("undef_empty_list", 32'he8b0_0000);
		issue_single("undef_coproc", 32'hee00_0a00);
		issue_single("undef_mrs", 32'he10f_0000);
	endtask

	// ####################
	initial begin
		rst_n      = 1'b0;
		insn       = 32'd0;
		insn_valid = 1'b0;
		lfsr       = 32'h88c5;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		reset_state();
		data_imm_ops();
		data_reg_ops();
		branches();
		multiplies();
		swi_calls();
		single_transfers();
		block_transfers();
		undefined_encodings();
		@(negedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d checks, %0d errors", cycles, checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
